/* hw/rv_ex_macros.svh */
`ifndef RV_EX_MACROS_SVH
`define RV_EX_MACROS_SVH

// Integer data path width
`define RV_XLEN 32

// One quotient bit per iteration
`define RV_DIV_CYCLES 32

// addi x0, x0, 0
`define RV_I_NOP 32'h0000_0013

`endif

/* hw/rv_ex_pkg.sv */
`include "rv_ex_macros.svh"

package rv_ex_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // Major opcodes handled by this stage
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    BRANCH = 7'b1100011
  } opcode_e;

  // Low three bits follow funct3, bit 3 marks the alternate form
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Branch offset bits are scattered over the word
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    b_type_t b_type;
  } instr_u;

endpackage

/* hw/rv_ex_dec_if.sv */
`timescale 1ns/1ps

interface rv_ex_dec_if;
  rv_ex_pkg::alu_op_e  alu_op;
  rv_ex_pkg::word_t    imm;
  logic                use_imm;
  logic                is_branch;
  logic                is_div;
  logic                reg_write;
  rv_ex_pkg::reg_idx_t rd;
  logic [2:0]          funct3;

  // Decoder side
  modport dec (
    output alu_op, imm, use_imm, is_branch, is_div, reg_write, rd, funct3
  );

  // Execute units and EX/MEM register
  modport exu (
    input alu_op, imm, use_imm, is_branch, is_div, reg_write, rd, funct3
  );
endinterface

/* hw/rv_ex_decode.sv */
`timescale 1ns/1ps

module rv_ex_decode (
  input rv_ex_pkg::instr_u instr,
  rv_ex_dec_if.dec         dec
);
  import rv_ex_pkg::*;

  opcode_e    opc;
  logic [2:0] f3;
  // funct7 bit 5 selects SUB / SRA
  logic       alt;
  // funct7 bit 0 marks the M extension
  logic       m_ext;
  word_t      imm_i;
  word_t      imm_b;

  assign opc   = opcode_e'(instr.r_type.opcode);
  assign f3    = instr.r_type.funct3;
  assign alt   = instr.r_type.funct7[5];
  assign m_ext = instr.r_type.funct7[0];

  // Sign-extended immediates, same word seen through two layouts
  assign imm_i = word_t'($signed(instr.i_type.imm12));
  assign imm_b = word_t'($signed({instr.b_type.imm_12, instr.b_type.imm_11,
                                  instr.b_type.imm_10_5, instr.b_type.imm_4_1, 1'b0}));

  // Fields that pass straight to the units
  assign dec.rd     = instr.r_type.rd;
  assign dec.funct3 = f3;

  always_comb begin
    dec.alu_op    = ALU_ADD;
    dec.imm       = imm_i;
    dec.use_imm   = 1'b0;
    dec.is_branch = 1'b0;
    dec.is_div    = 1'b0;
    dec.reg_write = 1'b0;
    case (opc)
      OP: begin
        // SUB and SRA both use the alternate bit
        dec.alu_op = alu_op_e'({alt & (f3 == 3'b000 || f3 == 3'b101), f3});
        if (m_ext) begin
          // Only DIV/DIVU/REM/REMU, multiplies write nothing
          dec.alu_op    = ALU_ADD;
          dec.is_div    = f3[2];
          dec.reg_write = f3[2];
        end else begin
          dec.reg_write = 1'b1;
        end
      end
      OP_IMM: begin
        // No SUBI, SRAI keeps its marker in imm bit 10
        dec.alu_op    = alu_op_e'({alt & (f3 == 3'b101), f3});
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
      end
      BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
      end
      default: begin
        // Other opcodes act as bubbles
        dec.reg_write = 1'b0;
      end
    endcase
  end

endmodule

/* hw/rv_ex_alu.sv */
`timescale 1ns/1ps

module rv_ex_alu (
  rv_ex_dec_if.exu         dec,
  input  rv_ex_pkg::word_t rs1_data,
  input  rv_ex_pkg::word_t rs2_data,
  output rv_ex_pkg::word_t result
);
  import rv_ex_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  assign op_a  = rs1_data;
  // Immediate form replaces rs2
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SRL:  result = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
      ALU_SLT:  result = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: result = word_t'(op_a < op_b);
      ALU_XOR:  result = op_a ^ op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_AND:  result = op_a & op_b;
      default:  result = '0;
    endcase
  end

endmodule

/* hw/rv_ex_branch.sv */
`timescale 1ns/1ps

module rv_ex_branch (
  rv_ex_dec_if.exu         dec,
  input  rv_ex_pkg::word_t pc,
  input  rv_ex_pkg::word_t rs1_data,
  input  rv_ex_pkg::word_t rs2_data,
  output logic             taken,
  output rv_ex_pkg::word_t target,
  output logic             trap
);
  import rv_ex_pkg::*;

  logic eq;
  logic lt_s;
  logic lt_u;
  logic cond;
  logic hit;

  assign eq   = rs1_data == rs2_data;
  assign lt_s = $signed(rs1_data) < $signed(rs2_data);
  assign lt_u = rs1_data < rs2_data;

  // funct3 bit 0 inverts the base condition
  always_comb begin
    case (dec.funct3[2:1])
      2'b00:   cond = eq;
      2'b10:   cond = lt_s;
      2'b11:   cond = lt_u;
      default: cond = 1'b0;
    endcase
    cond = cond ^ dec.funct3[0];
    // Encodings 010/011 are not branches
    if (dec.funct3[2:1] == 2'b01) begin
      cond = 1'b0;
    end
  end

  // PC-relative target
  assign target = pc + dec.imm;
  assign hit    = dec.is_branch & cond;

  // Misaligned target traps instead of redirecting
  assign trap  = hit & (|target[1:0]);
  assign taken = hit & ~trap;

endmodule

/* hw/rv_ex_div.sv */
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module rv_ex_div (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  rv_ex_dec_if.exu            dec,
  input  rv_ex_pkg::word_t    rs1_data,
  input  rv_ex_pkg::word_t    rs2_data,
  output logic                busy,
  output logic                done,
  output rv_ex_pkg::word_t    result,
  output rv_ex_pkg::reg_idx_t rd
);
  import rv_ex_pkg::*;

  localparam int CNT_W = $clog2(`RV_DIV_CYCLES);

  typedef enum logic {
    S_IDLE,
    S_EXEC
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] count;

  // Operand magnitudes and sign info at start
  logic  is_signed;
  logic  a_neg;
  logic  b_neg;
  word_t a_mag;
  word_t b_mag;

  // Latched operation
  word_t    divisor;
  word_t    rem_q;
  word_t    quo_q;
  logic     rem_sel;
  logic     neg_quo;
  logic     neg_rem;
  reg_idx_t rd_q;

  // One restoring step
  logic [`RV_XLEN:0] shifted;
  logic [`RV_XLEN:0] diff;
  word_t             rem_next;
  word_t             quo_next;

  assign is_signed = ~dec.funct3[0];
  assign a_neg     = is_signed & rs1_data[`RV_XLEN-1];
  assign b_neg     = is_signed & rs2_data[`RV_XLEN-1];
  assign a_mag     = a_neg ? -rs1_data : rs1_data;
  assign b_mag     = b_neg ? -rs2_data : rs2_data;

  assign shifted = {rem_q, quo_q[`RV_XLEN-1]};
  assign diff    = shifted - {1'b0, divisor};

  always_comb begin
    if (!diff[`RV_XLEN]) begin
      rem_next = diff[`RV_XLEN-1:0];
      quo_next = {quo_q[`RV_XLEN-2:0], 1'b1};
    end else begin
      rem_next = shifted[`RV_XLEN-1:0];
      quo_next = {quo_q[`RV_XLEN-2:0], 1'b0};
    end
  end

  // Sign fix on the final step
  // Most negative / -1 lands on 0x8000_0000 rem 0 by itself
  assign result = rem_sel ? (neg_rem ? -rem_next : rem_next)
                          : (neg_quo ? -quo_next : quo_next);
  assign rd     = rd_q;

  assign busy = state == S_EXEC;
  assign done = busy && count == CNT_W'(`RV_DIV_CYCLES - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      count <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_EXEC;
            count <= '0;
          end
        end
        S_EXEC: begin
          count <= count + 1'b1;
          if (done) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && start) begin
      divisor <= b_mag;
      quo_q   <= a_mag;
      rem_q   <= '0;
      rem_sel <= dec.funct3[1];
      // Divide by zero keeps all-ones quotient unsigned
      neg_quo <= (a_neg ^ b_neg) & (rs2_data != '0);
      // Remainder takes the dividend sign
      neg_rem <= a_neg;
      rd_q    <= dec.rd;
    end else if (busy) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
    end
  end

endmodule

/* hw/rv_ex_mem_reg.sv */
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module rv_ex_mem_reg (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic                flush,
  rv_ex_dec_if.exu            dec,
  input  rv_ex_pkg::instr_u   instr,
  input  rv_ex_pkg::word_t    alu_result,
  input  rv_ex_pkg::word_t    div_result,
  input  rv_ex_pkg::word_t    target,
  input  logic                taken,
  input  logic                trap_in,
  input  logic                div_done,
  input  rv_ex_pkg::reg_idx_t div_rd,
  output logic                mem_valid,
  output logic                mem_reg_write,
  output logic                redirect,
  output logic                trap,
  output rv_ex_pkg::word_t    mem_result,
  output rv_ex_pkg::word_t    redirect_target,
  output rv_ex_pkg::reg_idx_t mem_rd,
  output rv_ex_pkg::instr_u   mem_instr
);
  import rv_ex_pkg::*;

  logic   single_cap;
  // Word of the divide in flight is held here until done
  instr_u div_instr;

  assign single_cap = in_valid & ~dec.is_div;

  always_ff @(posedge clk) begin
    if (in_valid && dec.is_div) begin
      div_instr <= instr;
    end
  end

  // Flush turns the captured item into a bubble
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_valid     <= 1'b0;
      mem_reg_write <= 1'b0;
      redirect      <= 1'b0;
      trap          <= 1'b0;
      mem_instr     <= `RV_I_NOP;
    end else if (div_done) begin
      mem_valid     <= ~flush;
      // Every divide writes its rd
      mem_reg_write <= ~flush;
      redirect      <= 1'b0;
      trap          <= 1'b0;
      mem_instr     <= flush ? instr_u'(`RV_I_NOP) : div_instr;
    end else if (single_cap) begin
      mem_valid     <= ~flush;
      // Branches never write back
      mem_reg_write <= dec.reg_write & ~dec.is_branch & ~flush;
      redirect      <= taken & ~flush;
      trap          <= trap_in & ~flush;
      mem_instr     <= flush ? instr_u'(`RV_I_NOP) : instr;
    end else begin
      mem_valid     <= 1'b0;
      mem_reg_write <= 1'b0;
      redirect      <= 1'b0;
      trap          <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (div_done) begin
      mem_result <= div_result;
      mem_rd     <= div_rd;
    end else if (single_cap) begin
      mem_result      <= alu_result;
      mem_rd          <= dec.rd;
      redirect_target <= target;
    end
  end

endmodule

/* hw/rv_ex_stage.sv */
`timescale 1ns/1ps

module rv_ex_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  logic                flush,
  input  logic [31:0]         instr,
  input  rv_ex_pkg::word_t    pc,
  input  rv_ex_pkg::word_t    rs1_data,
  input  rv_ex_pkg::word_t    rs2_data,
  output logic                mem_valid,
  output logic                mem_reg_write,
  output rv_ex_pkg::reg_idx_t mem_rd,
  output rv_ex_pkg::word_t    mem_result,
  output logic [31:0]         mem_instr,
  output logic                redirect,
  output rv_ex_pkg::word_t    redirect_target,
  output logic                trap,
  output logic                busy
);
  import rv_ex_pkg::*;

  instr_u   instr_w;
  instr_u   mem_instr_w;
  // Strobe accepted only while the divider is idle
  logic     issue;
  logic     div_start;
  logic     div_busy;
  logic     div_done;
  word_t    div_result;
  reg_idx_t div_rd;
  word_t    alu_result;
  word_t    br_target;
  logic     br_taken;
  logic     br_trap;

  rv_ex_dec_if dec_bus ();

  assign instr_w   = instr;
  assign mem_instr = mem_instr_w;
  assign issue     = in_valid & ~div_busy;
  assign div_start = issue & dec_bus.is_div;
  assign busy      = div_busy;

  rv_ex_decode u_decode (
    .instr (instr_w),
    .dec   (dec_bus)
  );

  rv_ex_alu u_alu (
    .dec      (dec_bus),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result)
  );

  rv_ex_branch u_branch (
    .dec      (dec_bus),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .taken    (br_taken),
    .target   (br_target),
    .trap     (br_trap)
  );

  // Multi-cycle divide, result lands straight in EX/MEM
  rv_ex_div u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (div_start),
    .dec      (dec_bus),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .busy     (div_busy),
    .done     (div_done),
    .result   (div_result),
    .rd       (div_rd)
  );

  rv_ex_mem_reg u_mem_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (issue),
    .flush           (flush),
    .dec             (dec_bus),
    .instr           (instr_w),
    .alu_result      (alu_result),
    .div_result      (div_result),
    .target          (br_target),
    .taken           (br_taken),
    .trap_in         (br_trap),
    .div_done        (div_done),
    .div_rd          (div_rd),
    .mem_valid       (mem_valid),
    .mem_reg_write   (mem_reg_write),
    .redirect        (redirect),
    .trap            (trap),
    .mem_result      (mem_result),
    .redirect_target (redirect_target),
    .mem_rd          (mem_rd),
    .mem_instr       (mem_instr_w)
  );

endmodule

/* sim/rv_ex_properties.sv */
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module rv_ex_properties (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic busy,
  input logic redirect,
  input logic trap
);

  // Failure tallies, read by the testbench at the end
  int excl_fails  = 0;
  int issue_fails = 0;
  int busy_fails  = 0;

  // Cycles busy has been high so far
  logic [7:0] busy_len;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_len <= '0;
    end else if (busy) begin
      busy_len <= busy_len + 8'd1;
    end else begin
      busy_len <= '0;
    end
  end

  // A misaligned target never redirects
  a_redirect_trap: assert property (@(posedge clk) disable iff (!rst_n)
    !(redirect && trap))
    else begin
      $error("redirect and trap high in the same cycle");
      excl_fails = excl_fails + 1;
    end

  // No back-pressure, upstream must hold off during a divide
  a_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(in_valid && busy))
    else begin
      $error("in_valid pulsed while the divider was busy");
      issue_fails = issue_fails + 1;
    end

  a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> busy_len < 8'(`RV_DIV_CYCLES + 1))
    else begin
      $error("busy stayed high longer than the divide takes");
      busy_fails = busy_fails + 1;
    end

endmodule

bind rv_ex_stage rv_ex_properties u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_valid (in_valid),
  .busy     (busy),
  .redirect (redirect),
  .trap     (trap)
);

/* sim/rv_ex_tb.sv */
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module rv_ex_tb;
  import rv_ex_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_DIRECTED = 13;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
  // Worst case every operation is a divide
  localparam int TIMEOUT_NS   = (NUM_OPS * (`RV_DIV_CYCLES + 4) + RESET_CYCLES) * CLK_PERIOD;

  // One expected EX/MEM item, due is the negedge count where it shows up
  typedef struct packed {
    logic [31:0] due;
    logic [31:0] instr;
    word_t       result;
    word_t       target;
    reg_idx_t    rd;
    logic        wr;
    logic        redirect;
    logic        trap;
    logic        is_div;
    logic        flushed;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        flush;
  logic [31:0] instr;
  word_t       pc;
  word_t       rs1_data;
  word_t       rs2_data;
  logic        mem_valid;
  logic        mem_reg_write;
  reg_idx_t    mem_rd;
  word_t       mem_result;
  logic [31:0] mem_instr;
  logic        redirect;
  word_t       redirect_target;
  logic        trap;
  logic        busy;

  logic [15:0] lfsr;
  logic [31:0] cyc;
  exp_t        exp_q[$];
  int          checks;
  int          word_errs;
  int          idx_errs;
  int          flag_errs;
  int          other_errs;
  int          assert_errs;

  rv_ex_stage DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .flush           (flush),
    .instr           (instr),
    .pc              (pc),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .mem_valid       (mem_valid),
    .mem_reg_write   (mem_reg_write),
    .mem_rd          (mem_rd),
    .mem_result      (mem_result),
    .mem_instr       (mem_instr),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .trap            (trap),
    .busy            (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit, newest bit lands in bit 0
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Leans toward the corner values of signed and unsigned math
  function automatic word_t pick_operand();
    logic [2:0] sel;
    word_t      w;
    sel = 3'(take_bits(3));
    w   = take_bits(32);
    case (sel)
      3'd0:    return '0;
      3'd1:    return '1;
      3'd2:    return 32'h8000_0000;
      3'd3:    return w & 32'h0000_001f;
      default: return w;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_idx_t r2,
                                        input reg_idx_t r1, input logic [2:0] f3,
                                        input reg_idx_t rd);
    return {f7, r2, r1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_idx_t r1,
                                        input logic [2:0] f3, input reg_idx_t rd);
    return {imm, r1, f3, rd, 7'b0010011};
  endfunction

  // Offset bit 0 is implied zero
  function automatic logic [31:0] enc_b(input logic [12:0] imm, input reg_idx_t r2,
                                        input reg_idx_t r1, input logic [2:0] f3);
    return {imm[12], imm[10:5], r2, r1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t x, input word_t y);
    word_t r;
    case (f3)
      3'b000:  r = alt ? x - y : x + y;
      3'b001:  r = x << y[4:0];
      3'b010:  r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  r = (x < y) ? 32'd1 : 32'd0;
      3'b100:  r = x ^ y;
      3'b101: begin
        if (alt) begin
          r = $signed(x) >>> y[4:0];
        end else begin
          r = x >> y[4:0];
        end
      end
      3'b110:  r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  // RISC-V M rules incl. divide by zero and signed overflow
  function automatic word_t div_ref(input logic [2:0] f3, input word_t x, input word_t y);
    word_t q;
    word_t r;
    if (y == '0) begin
      q = '1;
      r = x;
    end else if (!f3[0] && x == 32'h8000_0000 && y == '1) begin
      q = x;
      r = '0;
    end else if (!f3[0]) begin
      q = $signed(x) / $signed(y);
      r = $signed(x) % $signed(y);
    end else begin
      q = x / y;
      r = x % y;
    end
    return f3[1] ? r : q;
  endfunction

  // Expected outcome of one instruction, decoded from raw bit positions
  function automatic exp_t ref_model(input logic [31:0] ins, input word_t pc_v,
                                     input word_t a, input word_t b);
    exp_t       e;
    logic [2:0] f3;
    logic       cond;
    word_t      imm_i;
    word_t      imm_b;
    f3    = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    e       = '0;
    e.instr = ins;
    e.rd    = ins[11:7];
    if (ins[6:0] == OP && ins[25]) begin
      // Only the divide half of M writes
      e.is_div = f3[2];
      e.wr     = f3[2];
      e.result = div_ref(f3, a, b);
    end else if (ins[6:0] == OP) begin
      e.wr     = 1'b1;
      e.result = alu_ref(f3, ins[30] && (f3 == 3'b000 || f3 == 3'b101), a, b);
    end else if (ins[6:0] == OP_IMM) begin
      e.wr     = 1'b1;
      e.result = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
    end else begin
      case (f3)
        3'b000:  cond = a == b;
        3'b001:  cond = a != b;
        3'b100:  cond = $signed(a) < $signed(b);
        3'b101:  cond = $signed(a) >= $signed(b);
        3'b110:  cond = a < b;
        3'b111:  cond = a >= b;
        default: cond = 1'b0;
      endcase
      e.target   = pc_v + imm_b;
      e.trap     = cond && e.target[1:0] != 2'b00;
      e.redirect = cond && !e.trap;
    end
    return e;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      word_errs++;
      $display("error %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    checks++;
    if (got !== exp) begin
      idx_errs++;
      $display("error %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      flag_errs++;
      $display("error %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_item(input exp_t e);
    if (e.flushed) begin
      // Bubble in place of the item
      check_flag("mem_valid", mem_valid, 1'b0);
      check_flag("mem_reg_write", mem_reg_write, 1'b0);
      check_flag("redirect", redirect, 1'b0);
      check_flag("trap", trap, 1'b0);
      check_word("mem_instr", mem_instr, `RV_I_NOP);
    end else begin
      check_flag("mem_valid", mem_valid, 1'b1);
      check_flag("mem_reg_write", mem_reg_write, e.wr);
      check_flag("redirect", redirect, e.redirect);
      check_flag("trap", trap, e.trap);
      check_word("mem_instr", mem_instr, e.instr);
      if (e.wr) begin
        check_word("mem_result", mem_result, e.result);
        check_idx("mem_rd", mem_rd, e.rd);
      end
      if (e.redirect || e.trap) begin
        check_word("redirect_target", redirect_target, e.target);
      end
    end
  endtask

  // Drive on the rising edge, a divide blocks until busy drops
  task automatic issue_op(input logic [31:0] ins, input word_t pc_v, input word_t a,
                          input word_t b, input logic fl);
    exp_t e;
    e         = ref_model(ins, pc_v, a, b);
    e.flushed = fl & ~e.is_div;
    @(posedge clk);
    e.due    = cyc + 32'd2 + (e.is_div ? 32'(`RV_DIV_CYCLES) : 32'd0);
    instr    <= ins;
    pc       <= pc_v;
    rs1_data <= a;
    rs2_data <= b;
    flush    <= e.flushed;
    in_valid <= 1'b1;
    exp_q.push_back(e);
    if (e.is_div) begin
      @(posedge clk);
      in_valid <= 1'b0;
      @(negedge clk);
      while (busy) begin
        @(negedge clk);
      end
    end
  endtask

  task automatic random_op();
    logic [1:0]  cls;
    logic [2:0]  f3;
    reg_idx_t    rd;
    reg_idx_t    r1;
    reg_idx_t    r2;
    logic [31:0] ins;
    word_t       pc_v;
    cls = 2'(take_bits(2));
    f3  = 3'(take_bits(3));
    rd  = reg_idx_t'(take_bits(5));
    r1  = reg_idx_t'(take_bits(5));
    r2  = reg_idx_t'(take_bits(5));
    case (cls)
      2'd0: ins = enc_r(take_bits(1) != 0 ? 7'h20 : 7'h00, r2, r1, f3, rd);
      2'd1: ins = enc_i(12'(take_bits(12)), r1, f3, rd);
      2'd2: begin
        // Fold 010/011 onto real branch kinds
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1;
        end
        ins = enc_b({12'(take_bits(12)), 1'b0}, r2, r1, f3);
      end
      default: ins = enc_r(7'h01, r2, r1, f3, rd);
    endcase
    pc_v = {30'(take_bits(30)), 2'b00};
    issue_op(ins, pc_v, pick_operand(), pick_operand(), 3'(take_bits(3)) == 3'd0);
  endtask

  // Monitor at the falling edge, where outputs are settled
  always @(negedge clk) begin
    exp_t e;
    logic busy_exp;
    cyc      = cyc + 32'd1;
    busy_exp = 1'b0;
    if (rst_n) begin
      if (exp_q.size() != 0) begin
        e        = exp_q[0];
        busy_exp = e.is_div && (cyc + `RV_DIV_CYCLES >= e.due) && (cyc < e.due);
      end
      check_flag("busy", busy, busy_exp);
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        e = exp_q.pop_front();
        compare_item(e);
      end else begin
        // Nothing due, also covers the state right after reset
        check_flag("mem_valid", mem_valid, 1'b0);
        check_flag("mem_reg_write", mem_reg_write, 1'b0);
        check_flag("redirect", redirect, 1'b0);
        check_flag("trap", trap, 1'b0);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired with %0d results still outstanding", exp_q.size());
    $display("Test failed");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    flush    = 1'b0;
    instr    = `RV_I_NOP;
    pc       = '0;
    rs1_data = '0;
    rs2_data = '0;
    lfsr     = 16'd21031;
    cyc      = '0;
    checks      = 0;
    word_errs   = 0;
    idx_errs    = 0;
    flag_errs   = 0;
    other_errs  = 0;
    assert_errs = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // ALU back to back, R and I forms
    issue_op(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), '0, 32'd5, 32'd7, 1'b0);
    issue_op(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd6), '0, 32'd5, 32'd7, 1'b0);
    issue_op(enc_i(12'h404, 5'd1, 3'b101, 5'd7), '0, 32'h8000_0000, '0, 1'b0);
    // Flushed item, then one that must pass untouched
    issue_op(enc_i(12'h7ff, 5'd1, 3'b000, 5'd8), '0, 32'd1, '0, 1'b1);
    issue_op(enc_i(12'h001, 5'd1, 3'b000, 5'd9), '0, 32'd1, '0, 1'b0);
    // Taken BEQ to a misaligned target, taken BNE backwards
    issue_op(enc_b(13'h0006, 5'd2, 5'd1, 3'b000), 32'h100, 32'd3, 32'd3, 1'b0);
    issue_op(enc_b(13'h1ff8, 5'd2, 5'd1, 3'b001), 32'h200, 32'd1, 32'd2, 1'b0);
    // Divide corners
    issue_op(enc_r(7'h01, 5'd2, 5'd1, 3'b100, 5'd10), '0, 32'h8000_0000, '1, 1'b0);
    issue_op(enc_r(7'h01, 5'd2, 5'd1, 3'b110, 5'd11), '0, 32'h8000_0000, '1, 1'b0);
    issue_op(enc_r(7'h01, 5'd2, 5'd1, 3'b101, 5'd12), '0, 32'h1234, '0, 1'b0);
    issue_op(enc_r(7'h01, 5'd2, 5'd1, 3'b111, 5'd13), '0, 32'h1234, '0, 1'b0);
    issue_op(enc_r(7'h01, 5'd2, 5'd1, 3'b100, 5'd14), '0, -32'sd7, '0, 1'b0);
    issue_op(enc_r(7'h01, 5'd2, 5'd1, 3'b110, 5'd15), '0, -32'sd7, '0, 1'b0);

    repeat (NUM_RANDOM) random_op();
    @(posedge clk);
    in_valid <= 1'b0;
    flush    <= 1'b0;

    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    if (busy) begin
      other_errs++;
      $display("divider still busy after the last result was taken");
    end
    assert_errs = DUT.u_props.excl_fails + DUT.u_props.issue_fails +
                  DUT.u_props.busy_fails;
    $display("checks %0d, errors word %0d, index %0d, flag %0d, other %0d, assertion %0d",
             checks, word_errs, idx_errs, flag_errs, other_errs, assert_errs);
    if (word_errs + idx_errs + flag_errs + other_errs + assert_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* rv_ex.f */
+incdir+hw
hw/rv_ex_pkg.sv
hw/rv_ex_dec_if.sv
hw/rv_ex_decode.sv
hw/rv_ex_alu.sv
hw/rv_ex_branch.sv
hw/rv_ex_div.sv
hw/rv_ex_mem_reg.sv
hw/rv_ex_stage.sv
sim/rv_ex_properties.sv
sim/rv_ex_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := rv_ex_tb
FILELIST   := rv_ex.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee /dev/stderr | grep -Fx "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
